/* source/isa_pkg.sv */
package isa_pkg;

    // Major opcodes, bits 6:0 of the instruction
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 for arithmetic and logic
    localparam logic [2:0] F3_ADD   = 3'b000;
    localparam logic [2:0] F3_SLT   = 3'b010;
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_OR    = 3'b110;
    localparam logic [2:0] F3_AND   = 3'b111;

    // funct3 for branches and word accesses
    localparam logic [2:0] F3_BEQ   = 3'b000;
    localparam logic [2:0] F3_BNE   = 3'b001;
    localparam logic [2:0] F3_LW_SW = 3'b010;

    // Index into funct7, set for SUB
    localparam int F7_SUB = 5;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

endpackage

/* source/core_pkg.sv */
package core_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Register address width
    localparam int REG_AW = 5;

    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Source of the register write data
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC_PLUS4
    } wb_sel_e;

endpackage

/* source/exec_if.sv */
`timescale 1ns/1ps

interface exec_if
    import isa_pkg::*;
    import core_pkg::*;
();

    // Operands and immediate
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   rs2_data;

    // Operation and destination
    alu_op_e           alu_op;
    logic [REG_AW-1:0] rd;
    wb_sel_e           wb_sel;

    // Control flags
    logic              rf_we;
    logic              mem_we;
    logic              is_branch;
    logic              is_jal;
    logic              br_ne;
    logic              halt;

    modport dec (
        output pc, imm, op_a, op_b, rs2_data,
        output alu_op, rd, wb_sel,
        output rf_we, mem_we, is_branch, is_jal, br_ne, halt
    );

    modport alu (input op_a, op_b, alu_op);

    modport br (input pc, imm, op_a, rs2_data, is_branch, is_jal, br_ne);

    modport cmt (input pc, rd, wb_sel, rf_we, mem_we, rs2_data, halt);

endinterface

/* source/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic [XLEN-1:0]   inst_i,
    input  logic [XLEN-1:0]   pc_i,
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    exec_if.dec               ex
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    logic            zero_a;

    // Shared by register and immediate arithmetic
    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic sub);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = sub ? ALU_SUB : ALU_ADD;
            F3_SLT:  op = ALU_SLT;
            F3_XOR:  op = ALU_XOR;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    always_comb begin
        // Defaults describe a no-op
        ex.alu_op    = ALU_ADD;
        ex.wb_sel    = WB_ALU;
        ex.rf_we     = 1'b0;
        ex.mem_we    = 1'b0;
        ex.is_branch = 1'b0;
        ex.is_jal    = 1'b0;
        ex.br_ne     = 1'b0;
        ex.halt      = 1'b0;
        imm          = imm_i;
        use_imm      = 1'b0;
        zero_a       = 1'b0;
        case (opcode)
            OPC_OP: begin
                ex.alu_op = f3_to_alu(funct3, funct7[F7_SUB]);
                ex.rf_we  = 1'b1;
            end
            OPC_OP_IMM: begin
                ex.alu_op = f3_to_alu(funct3, 1'b0);
                ex.rf_we  = 1'b1;
                use_imm   = 1'b1;
            end
            OPC_LUI: begin
                ex.alu_op = ALU_PASS_B;
                ex.rf_we  = 1'b1;
                imm       = imm_u;
                use_imm   = 1'b1;
                zero_a    = 1'b1;
            end
            OPC_LOAD: begin
                // Only word loads exist
                ex.rf_we  = (funct3 == F3_LW_SW);
                ex.wb_sel = WB_LOAD;
                use_imm   = 1'b1;
            end
            OPC_STORE: begin
                ex.mem_we = (funct3 == F3_LW_SW);
                imm       = imm_s;
                use_imm   = 1'b1;
            end
            OPC_BRANCH: begin
                ex.is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                ex.br_ne     = (funct3 == F3_BNE);
                imm          = imm_b;
            end
            OPC_JAL: begin
                ex.is_jal = 1'b1;
                ex.rf_we  = 1'b1;
                ex.wb_sel = WB_PC_PLUS4;
                imm       = imm_j;
            end
            OPC_SYSTEM: begin
                ex.halt = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign ex.pc       = pc_i;
    assign ex.rd       = inst_i[11:7];
    assign ex.imm      = imm;
    assign ex.rs2_data = rs2_data_i;
    assign ex.op_a     = zero_a ? '0 : rs1_data_i;
    assign ex.op_b     = use_imm ? imm : rs2_data_i;

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic [REG_AW-1:0] raddr1_i,
    input  logic [REG_AW-1:0] raddr2_i,
    output logic [XLEN-1:0]   rdata1_o,
    output logic [XLEN-1:0]   rdata2_o,
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i,
    input  logic              we_i
);

    // x0 has no storage
    logic [XLEN-1:0] regs_q [31:1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu
    import isa_pkg::*;
    import core_pkg::*;
(
    exec_if.alu             ex,
    output logic [XLEN-1:0] result_o
);

    logic lt_signed;

    assign lt_signed = $signed(ex.op_a) < $signed(ex.op_b);

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:    result_o = ex.op_a + ex.op_b;
            ALU_SUB:    result_o = ex.op_a - ex.op_b;
            ALU_AND:    result_o = ex.op_a & ex.op_b;
            ALU_OR:     result_o = ex.op_a | ex.op_b;
            ALU_XOR:    result_o = ex.op_a ^ ex.op_b;
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_signed};
            // LUI immediate goes straight through
            ALU_PASS_B: result_o = ex.op_b;
            default:    result_o = ex.op_a + ex.op_b;
        endcase
    end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
    import core_pkg::*;
(
    exec_if.br              ex,
    output logic            take_o,
    output logic [XLEN-1:0] target_o
);

    logic equal;
    logic cond_met;

    assign equal = (ex.op_a == ex.rs2_data);

    // BNE inverts the equality test
    assign cond_met = ex.br_ne ? !equal : equal;

    assign take_o = ex.is_jal || (ex.is_branch && cond_met);

    // Same adder for branch and jump targets
    assign target_o = ex.pc + ex.imm;

endmodule

/* source/commit_unit.sv */
`timescale 1ns/1ps

module commit_unit
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    exec_if.cmt               ex,
    input  logic [XLEN-1:0]   alu_result_i,
    input  logic              take_i,
    input  logic [XLEN-1:0]   target_i,
    input  logic [XLEN-1:0]   dmem_rdata_i,
    output logic [XLEN-1:0]   pc_o,
    output logic [REG_AW-1:0] rf_waddr_o,
    output logic [XLEN-1:0]   rf_wdata_o,
    output logic              rf_we_o,
    output logic              dmem_we_o,
    output logic [XLEN-1:0]   dmem_wdata_o,
    output logic              halted_o,
    output logic              retire_o,
    output logic [XLEN-1:0]   retire_pc_o,
    output logic [REG_AW-1:0] retire_rd_o,
    output logic [XLEN-1:0]   retire_data_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_next;
    logic            running_q;
    logic            halted_q;

    assign pc_plus4 = pc_q + 32'd4;

    // EBREAK holds the pc on itself
    assign pc_next = ex.halt ? pc_q : (take_i ? target_i : pc_plus4);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q      <= RESET_PC;
            running_q <= 1'b0;
            halted_q  <= 1'b0;
        end else begin
            if (running_q) begin
                pc_q <= pc_next;
            end
            if (running_q && ex.halt) begin
                running_q <= 1'b0;
                halted_q  <= 1'b1;
            end else if (!halted_q) begin
                running_q <= 1'b1;
            end
        end
    end

    always_comb begin
        case (ex.wb_sel)
            WB_LOAD:     rf_wdata_o = dmem_rdata_i;
            WB_PC_PLUS4: rf_wdata_o = pc_plus4;
            default:     rf_wdata_o = alu_result_i;
        endcase
    end

    // Writes only happen while the core runs
    assign rf_waddr_o   = ex.rd;
    assign rf_we_o      = running_q && ex.rf_we;
    assign dmem_we_o    = running_q && ex.mem_we;
    assign dmem_wdata_o = ex.rs2_data;

    assign pc_o     = pc_q;
    assign halted_o = halted_q;

    // Report of the instruction that commits at the next edge
    assign retire_o      = running_q;
    assign retire_pc_o   = ex.pc;
    assign retire_rd_o   = ex.rf_we ? ex.rd : '0;
    assign retire_data_o = ex.mem_we ? ex.rs2_data : rf_wdata_o;

endmodule

/* source/core_top.sv */
`timescale 1ns/1ps

module core_top
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    // Instruction memory
    output logic [XLEN-1:0]   imem_addr_o,
    input  logic [XLEN-1:0]   imem_data_i,
    // Data memory
    output logic [XLEN-1:0]   dmem_addr_o,
    input  logic [XLEN-1:0]   dmem_rdata_i,
    output logic              dmem_we_o,
    output logic [XLEN-1:0]   dmem_wdata_o,
    // Status and retire report
    output logic              halted_o,
    output logic              retire_o,
    output logic [XLEN-1:0]   retire_pc_o,
    output logic [REG_AW-1:0] retire_rd_o,
    output logic [XLEN-1:0]   retire_data_o
);

    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [REG_AW-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;
    logic              rf_we;
    logic              take_branch;
    logic [XLEN-1:0]   branch_target;

    exec_if ex_bus ();

    // Fetch address doubles as the decode pc
    decode_unit u_decode (
        .inst_i     (imem_data_i),
        .pc_i       (imem_addr_o),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex         (ex_bus.dec)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .we_i     (rf_we)
    );

    // ALU result is also the data address
    alu u_alu (
        .ex       (ex_bus.alu),
        .result_o (dmem_addr_o)
    );

    branch_unit u_branch (
        .ex       (ex_bus.br),
        .take_o   (take_branch),
        .target_o (branch_target)
    );

    commit_unit u_commit (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .ex            (ex_bus.cmt),
        .alu_result_i  (dmem_addr_o),
        .take_i        (take_branch),
        .target_i      (branch_target),
        .dmem_rdata_i  (dmem_rdata_i),
        .pc_o          (imem_addr_o),
        .rf_waddr_o    (rf_waddr),
        .rf_wdata_o    (rf_wdata),
        .rf_we_o       (rf_we),
        .dmem_we_o     (dmem_we_o),
        .dmem_wdata_o  (dmem_wdata_o),
        .halted_o      (halted_o),
        .retire_o      (retire_o),
        .retire_pc_o   (retire_pc_o),
        .retire_rd_o   (retire_rd_o),
        .retire_data_o (retire_data_o)
    );

endmodule

/* tests/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    // 10 ns clock period
    localparam int HALF_PERIOD_NS = 5;
    localparam int RESET_CYCLES   = 5;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

/* tests/core_tb.sv */
`timescale 1ns/1ps

module core_tb
    import core_pkg::*;
();

    localparam int              MEM_WORDS = 64;
    localparam logic [XLEN-1:0] MEM_BYTES = 32'd256;
    localparam string           VEC_FILE  = "tests/core_vectors.txt";

    logic              clk;
    logic              arst_n;
    logic [XLEN-1:0]   imem_addr;
    logic [XLEN-1:0]   imem_data;
    logic [XLEN-1:0]   dmem_addr;
    logic [XLEN-1:0]   dmem_rdata;
    logic              dmem_we;
    logic [XLEN-1:0]   dmem_wdata;
    logic              halted;
    logic              retire;
    logic [XLEN-1:0]   retire_pc;
    logic [REG_AW-1:0] retire_rd;
    logic [XLEN-1:0]   retire_data;

    logic [XLEN-1:0] imem [MEM_WORDS];
    logic [XLEN-1:0] dmem [MEM_WORDS];

    // Contents of the vector file
    logic [XLEN-1:0] exp_pc_q [$];
    logic [XLEN-1:0] exp_rd_q [$];
    logic [XLEN-1:0] exp_data_q [$];
    logic            exp_chk_q [$];
    logic [XLEN-1:0] final_addr_q [$];
    logic [XLEN-1:0] final_data_q [$];

    int errors  = 0;
    int retired = 0;

    clk_gen i_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    core_top i_dut (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .imem_addr_o   (imem_addr),
        .imem_data_i   (imem_data),
        .dmem_addr_o   (dmem_addr),
        .dmem_rdata_i  (dmem_rdata),
        .dmem_we_o     (dmem_we),
        .dmem_wdata_o  (dmem_wdata),
        .halted_o      (halted),
        .retire_o      (retire),
        .retire_pc_o   (retire_pc),
        .retire_rd_o   (retire_rd),
        .retire_data_o (retire_data)
    );

    // Unwritten memory words carry their own byte address
    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        return 32'h5a5a_0000 ^ addr;
    endfunction

    assign imem_data  = (imem_addr < MEM_BYTES) ? imem[imem_addr[7:2]] : fill_word(imem_addr);
    assign dmem_rdata = (dmem_addr < MEM_BYTES) ? dmem[dmem_addr[7:2]] : fill_word(dmem_addr);

    task automatic check(input string name, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_vectors();
        int              fd;
        int              n;
        int              want;
        string           line;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] c;
        logic [XLEN-1:0] d;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = fill_word(32'(i * 4));
            dmem[i] = fill_word(32'(i * 4));
        end
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n    = 0;
            want = 0;
            case (line[0])
                "I": begin
                    want = 2;
                    n = $sscanf(line, "I %h %h", a, b);
                    imem[a[7:2]] = b;
                end
                "D": begin
                    want = 2;
                    n = $sscanf(line, "D %h %h", a, b);
                    dmem[a[7:2]] = b;
                end
                "R": begin
                    want = 4;
                    n = $sscanf(line, "R %h %h %h %h", a, b, c, d);
                    exp_pc_q.push_back(a);
                    exp_rd_q.push_back(b);
                    exp_data_q.push_back(c);
                    exp_chk_q.push_back(d[0]);
                end
                "M": begin
                    want = 2;
                    n = $sscanf(line, "M %h %h", a, b);
                    final_addr_q.push_back(a);
                    final_data_q.push_back(b);
                end
                default: begin
                end
            endcase
            if (n != want) begin
                $display("Vector file line does not parse: %s", line);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // Data memory stores at the rising edge
    always @(posedge clk) begin
        if (dmem_we && (dmem_addr < MEM_BYTES)) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end else if (dmem_we) begin
            $display("Store to %h lies outside the data memory", dmem_addr);
            errors++;
        end
    end

    // Retire trace, sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n && retire) begin
            if (halted) begin
                $display("Core retired an instruction after it halted");
                errors++;
            end
            if (retired == 0) begin
                check("first retire pc", RESET_PC, retire_pc);
            end
            if (retired >= exp_pc_q.size()) begin
                $display("Retire at pc %h goes past the end of the expected trace", retire_pc);
                errors++;
            end else begin
                check($sformatf("retire %0d pc", retired), exp_pc_q[retired], retire_pc);
                check($sformatf("retire %0d rd", retired), exp_rd_q[retired], 32'(retire_rd));
                if (exp_chk_q[retired]) begin
                    check($sformatf("retire %0d data", retired), exp_data_q[retired],
                          retire_data);
                end
            end
            retired++;
        end
    end

    initial begin
        int              limit;
        int              cycles;
        logic            timed_out;
        logic [XLEN-1:0] addr;
        cycles    = 0;
        timed_out = 1'b0;
        load_vectors();
        limit = 2 * exp_pc_q.size() + 20;

        // Outputs while reset is held
        repeat (2) @(negedge clk);
        check("reset retire", '0, 32'(retire));
        check("reset dmem_we", '0, 32'(dmem_we));
        check("reset halted", '0, 32'(halted));
        check("reset pc", RESET_PC, imem_addr);

        wait (arst_n);
        while (!halted && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (!halted && (cycles >= limit)) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            $display("Core did not halt within %0d cycles", limit);
            errors++;
        end else begin
            // A few idle cycles show that nothing retires after EBREAK
            repeat (3) @(negedge clk);
            check("halted stays high", 32'd1, 32'(halted));
            // The last trace entry is the EBREAK, where the pc stays
            check("pc held at ebreak", exp_pc_q[exp_pc_q.size() - 1], imem_addr);
            if (retired != exp_pc_q.size()) begin
                $display("Trace incomplete, %0d of %0d instructions retired",
                         retired, exp_pc_q.size());
                errors++;
            end
            for (int k = 0; k < final_addr_q.size(); k++) begin
                addr = final_addr_q[k];
                check($sformatf("memory %h", addr), final_data_q[k], dmem[addr[7:2]]);
            end
        end

        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* tests/core_vectors.txt */
# I addr word = program, D addr word = initial data memory
# R pc rd data check = retire trace (check 0 skips data), M addr word = final memory
I 00 00500093 addi x1, x0, 5
I 04 FFD00113 addi x2, x0, -3
I 08 002081B3 add  x3, x1, x2
I 0C 40208233 sub  x4, x1, x2
I 10 0020F2B3 and  x5, x1, x2
I 14 0020E333 or   x6, x1, x2
I 18 0020C3B3 xor  x7, x1, x2
I 1C 00112433 slt  x8, x2, x1
I 20 0020A4B3 slt  x9, x1, x2
I 24 12345537 lui  x10, 0x12345
I 28 00708013 addi x0, x1, 7
I 2C 001005B3 add  x11, x0, x1
I 30 04000613 addi x12, x0, 0x40
I 34 00A62223 sw   x10, 4(x12)
I 38 00462683 lw   x13, 4(x12)
I 3C 00062703 lw   x14, 0(x12)
I 40 00B08463 beq  x1, x11, +8
I 44 00100793 addi x15, x0, 1
I 48 00B09463 bne  x1, x11, +8
I 4C 00208463 beq  x1, x2, +8
I 50 00209463 bne  x1, x2, +8
I 54 00100793 addi x15, x0, 1
I 58 0080086F jal  x16, +8
I 5C 00100793 addi x15, x0, 1
I 60 01062423 sw   x16, 8(x12)
I 64 00D808B3 add  x17, x16, x13
I 68 00100073 ebreak
D 40 CAFEF00D
R 00 01 00000005 1
R 04 02 FFFFFFFD 1
R 08 03 00000002 1
R 0C 04 00000008 1
R 10 05 00000005 1
R 14 06 FFFFFFFD 1
R 18 07 FFFFFFF8 1
R 1C 08 00000001 1
R 20 09 00000000 1
R 24 0A 12345000 1
R 28 00 0000000C 1
R 2C 0B 00000005 1
R 30 0C 00000040 1
R 34 00 12345000 1
R 38 0D 12345000 1
R 3C 0E CAFEF00D 1
R 40 00 00000000 0
R 48 00 00000000 0
R 4C 00 00000000 0
R 50 00 00000000 0
R 58 10 0000005C 1
R 60 00 0000005C 1
R 64 11 1234505C 1
R 68 00 00000000 0
M 40 CAFEF00D
M 44 12345000
M 48 0000005C

/* sim.f */
source/isa_pkg.sv
source/core_pkg.sv
source/exec_if.sv
source/decode_unit.sv
source/reg_file.sv
source/alu.sv
source/branch_unit.sv
source/commit_unit.sv
source/core_top.sv
tests/clk_gen.sv
tests/core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f sim.f --top-module core_tb -o core_sim
out=$(./obj_dir/core_sim)
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
